// ==== hw/spi_params.svh ====
// SPI controller widths, FIFO sizing, register offsets and register reset values
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

//////////////////////////////
// Widths and sizes
`define SPI_DATA_W      8       // Frame data width
`define SPI_BUS_W       32      // APB data width
`define SPI_FIFO_DEPTH  8       // Entries per FIFO
`define SPI_FIFO_AW     3       // FIFO pointer width
`define SPI_DIV_W       12      // SCLK divider width
`define SPI_CS_W        4       // Chip selects

//////////////////////////////
// Register offsets, word aligned
`define SPI_REG_SCKDIV  8'h00
`define SPI_REG_SCKMODE 8'h04
`define SPI_REG_CSID    8'h10
`define SPI_REG_CSDEF   8'h14
`define SPI_REG_CSMODE  8'h18
`define SPI_REG_FMT     8'h40
`define SPI_REG_TXDATA  8'h48
`define SPI_REG_RXDATA  8'h4C
`define SPI_REG_TXMARK  8'h50
`define SPI_REG_RXMARK  8'h54
`define SPI_REG_IE      8'h70
`define SPI_REG_IP      8'h74

// Reset values
`define SPI_RST_SCKDIV   3
`define SPI_RST_CSDEF    {`SPI_CS_W{1'b1}}  // All chip selects inactive high
`define SPI_RST_FRAMELEN 8

`endif

// ==== hw/spi_pkg.sv ====
// Package with the transfer state and chip-select mode enums
`default_nettype none

package spi_pkg;

    // Transfer engine state, one half SCLK period per step
    typedef enum logic [1:0] {
        XferIdle,   // Nothing shifting
        XferLead,   // First half of a bit
        XferTrail,  // Second half of a bit
        XferGap     // Chip select released between frames
    } xferStateT;

    // Chip select mode, 1 and 2 act as auto
    typedef enum logic [1:0] {
        CsAuto = 2'd0,
        CsOff  = 2'd3
    } csModeT;

endpackage

`default_nettype wire

// ==== hw/spiRegs.sv ====
// APB register file with readback, watermark interrupt and configuration interlock
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiRegs (
    input  logic                   PCLK,
    input  logic                   PRESETn,
    input  logic                   PSEL,
    input  logic                   PENABLE,
    input  logic                   PWRITE,
    input  logic [7:0]             PADDR,
    input  logic [`SPI_BUS_W-1:0]  PWDATA,
    input  logic                   txFull,
    input  logic                   txEmpty,
    input  logic [`SPI_FIFO_AW:0]  txCount,
    input  logic                   rxEmpty,
    input  logic [`SPI_FIFO_AW:0]  rxCount,
    input  logic [`SPI_DATA_W-1:0] rxHead,
    input  logic                   xferIdle,
    input  logic                   xferBusy,
    output logic                   PREADY,
    output logic [`SPI_BUS_W-1:0]  PRDATA,
    output logic                   SPIIntr,
    output logic [`SPI_DIV_W-1:0]  sckDiv,
    output logic [1:0]             sckMode,   // [1] polarity, [0] phase
    output logic [1:0]             csId,
    output logic [`SPI_CS_W-1:0]   csDef,
    output spi_pkg::csModeT        csMode,
    output logic [3:0]             frameLen,
    output logic                   txPush,
    output logic [`SPI_DATA_W-1:0] txData,
    output logic                   rxPop
);

    logic [7:0]              regAddr;     // Word aligned offset
    logic                    engineIdle;  // No frame shifting and none queued
    logic                    fifoReg;     // Data and status regs bypass the interlock
    logic                    accWrite;
    logic                    accRead;
    logic [3:0]              fmtLen;      // Frame length field of a FMT write
    logic [`SPI_FIFO_AW-1:0] txMark;
    logic [`SPI_FIFO_AW-1:0] rxMark;
    logic [1:0]              ie;
    logic [1:0]              ip;

    //////////////////////////////
    // APB decode and interlock
    assign regAddr    = {PADDR[7:2], 2'b00};
    assign engineIdle = xferIdle & txEmpty;
    assign fifoReg    = (regAddr == `SPI_REG_TXDATA) | (regAddr == `SPI_REG_RXDATA) |
                        (regAddr == `SPI_REG_IP);
    assign PREADY     = fifoReg | engineIdle;   // Config access waits for the transfer
    assign accWrite   = PSEL & PENABLE & PWRITE & PREADY;
    assign accRead    = PSEL & PENABLE & ~PWRITE & PREADY;

    // FIFO strobes, a write into a full FIFO is lost
    assign txPush  = accWrite & (regAddr == `SPI_REG_TXDATA) & ~txFull;
    assign txData  = PWDATA[`SPI_DATA_W-1:0];
    assign rxPop   = accRead & (regAddr == `SPI_REG_RXDATA) & ~rxEmpty;
    assign fmtLen  = PWDATA[19:16];
    assign SPIIntr = |(ip & ie);

    // Control registers and pending bits
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            sckDiv   <= `SPI_DIV_W'(`SPI_RST_SCKDIV);
            sckMode  <= '0;
            csId     <= '0;
            csDef    <= `SPI_RST_CSDEF;
            csMode   <= spi_pkg::CsAuto;
            frameLen <= 4'(`SPI_RST_FRAMELEN);
            txMark   <= '0;
            rxMark   <= '0;
            ie       <= '0;
            ip       <= '0;
        end else begin
            ip[0] <= txCount < {1'b0, txMark};  // Transmit side running low
            ip[1] <= rxCount > {1'b0, rxMark};  // Receive side has data waiting
            if (accWrite) begin
                case (regAddr)
                    `SPI_REG_SCKDIV:  sckDiv  <= PWDATA[`SPI_DIV_W-1:0];
                    `SPI_REG_SCKMODE: sckMode <= PWDATA[1:0];
                    `SPI_REG_CSID:    csId    <= PWDATA[1:0];
                    `SPI_REG_CSDEF:   csDef   <= PWDATA[`SPI_CS_W-1:0];
                    `SPI_REG_CSMODE:  csMode  <= spi_pkg::csModeT'(PWDATA[1:0]);
                    `SPI_REG_TXMARK:  txMark  <= PWDATA[`SPI_FIFO_AW-1:0];
                    `SPI_REG_RXMARK:  rxMark  <= PWDATA[`SPI_FIFO_AW-1:0];
                    `SPI_REG_IE:      ie      <= PWDATA[1:0];
                    `SPI_REG_FMT: begin
                        // Out of range lengths fall back to a full byte
                        if (fmtLen == 4'd0 || fmtLen > 4'(`SPI_DATA_W))
                            frameLen <= 4'(`SPI_DATA_W);
                        else
                            frameLen <= fmtLen;
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // Readback, sampled from PADDR every cycle
    always_ff @(posedge PCLK) begin
        case (regAddr)
            `SPI_REG_SCKDIV:  PRDATA <= `SPI_BUS_W'(sckDiv);
            `SPI_REG_SCKMODE: PRDATA <= `SPI_BUS_W'(sckMode);
            `SPI_REG_CSID:    PRDATA <= `SPI_BUS_W'(csId);
            `SPI_REG_CSDEF:   PRDATA <= `SPI_BUS_W'(csDef);
            `SPI_REG_CSMODE:  PRDATA <= `SPI_BUS_W'(csMode);
            `SPI_REG_FMT:     PRDATA <= `SPI_BUS_W'({frameLen, 16'h0000});
            `SPI_REG_TXDATA:  PRDATA <= {txFull, {(`SPI_BUS_W-1){1'b0}}};
            `SPI_REG_RXDATA:  PRDATA <= {rxEmpty, ~xferBusy,
                                         {(`SPI_BUS_W-2-`SPI_DATA_W){1'b0}}, rxHead};
            `SPI_REG_TXMARK:  PRDATA <= `SPI_BUS_W'(txMark);
            `SPI_REG_RXMARK:  PRDATA <= `SPI_BUS_W'(rxMark);
            `SPI_REG_IE:      PRDATA <= `SPI_BUS_W'(ie);
            `SPI_REG_IP:      PRDATA <= `SPI_BUS_W'(ip);
            default:          PRDATA <= '0;   // Unmapped offsets read zero
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/spiFifo.sv ====
// Synchronous circular FIFO with occupancy count
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiFifo #(
    parameter int Depth = `SPI_FIFO_DEPTH,
    parameter int Width = `SPI_DATA_W
) (
    input  logic                       PCLK,
    input  logic                       PRESETn,
    input  logic                       push,
    input  logic [Width-1:0]           pushData,
    input  logic                       pop,
    output logic [Width-1:0]           popData,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(Depth+1)-1:0] count
);

    localparam int AW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CW = $clog2(Depth + 1);

    logic [Width-1:0] mem [Depth];
    logic [AW-1:0]    wrPtr;
    logic [AW-1:0]    rdPtr;
    logic             doPush;   // Push that lands
    logic             doPop;    // Pop that lands

    assign full    = (count == CW'(Depth));
    assign empty   = (count == '0);
    assign doPush  = push & ~full;
    assign doPop   = pop & ~empty;
    assign popData = mem[rdPtr];    // Head entry, valid while not empty

    always_ff @(posedge PCLK) begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    // Pointers wrap at Depth, so any depth works
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= (wrPtr == AW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == AW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            count <= count + CW'(doPush) - CW'(doPop);
        end
    end

endmodule

`default_nettype wire

// ==== hw/spiClockGen.sv ====
// SCLK half-period enable generator
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiClockGen (
    input  logic                  PCLK,
    input  logic                  PRESETn,
    input  logic [`SPI_DIV_W-1:0] sckDiv,
    output logic                  sclkTick    // One PCLK every sckDiv+1 cycles
);

    logic [`SPI_DIV_W-1:0] divCnt;

    // Compare with >= so a smaller divisor written mid-count restarts at once
    assign sclkTick = (divCnt >= sckDiv);

    always_ff @(posedge PCLK) begin
        if (!PRESETn)
            divCnt <= '0;
        else if (sclkTick)
            divCnt <= '0;
        else
            divCnt <= divCnt + 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/spiXfer.sv ====
// Transfer FSM with shift registers, SPICLK and chip-select generation
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiXfer (
    input  logic                   PCLK,
    input  logic                   PRESETn,
    input  logic                   sclkTick,
    input  logic [1:0]             sckMode,   // [1] polarity, [0] phase
    input  logic [1:0]             csId,
    input  logic [`SPI_CS_W-1:0]   csDef,
    input  spi_pkg::csModeT        csMode,
    input  logic [3:0]             frameLen,
    input  logic                   txEmpty,
    input  logic [`SPI_DATA_W-1:0] txHead,
    input  logic                   SPIIn,
    output logic                   txPop,
    output logic                   rxPush,
    output logic [`SPI_DATA_W-1:0] rxByte,
    output logic                   xferIdle,
    output logic                   xferBusy,
    output logic                   SPIOut,
    output logic                   SPICLK,
    output logic [`SPI_CS_W-1:0]   SPICS
);

    spi_pkg::xferStateT     state;
    spi_pkg::xferStateT     nextState;
    logic [2:0]             bitCnt;     // Bit within the frame
    logic [`SPI_DATA_W-1:0] txShift;
    logic [`SPI_DATA_W-1:0] rxShift;
    logic                   lastBit;
    logic                   loadFrame;
    logic                   sampleBit;
    logic                   shiftBit;
    logic                   clkActive;  // SCLK away from its idle level
    logic [`SPI_CS_W-1:0]   csSel;

    //////////////////////////////
    // Step strobes, all on sclkTick
    assign lastBit   = ({1'b0, bitCnt} + 4'd1) == frameLen;
    assign loadFrame = sclkTick & ~txEmpty &
                       ((state == spi_pkg::XferIdle) | (state == spi_pkg::XferGap));
    assign sampleBit = sclkTick & (state == spi_pkg::XferLead);   // Lead to trail
    assign shiftBit  = sclkTick & (state == spi_pkg::XferTrail) & ~lastBit;
    assign rxPush    = sclkTick & (state == spi_pkg::XferTrail) & lastBit;
    assign txPop     = loadFrame;   // Head leaves the FIFO as it is loaded

    assign xferIdle = (state == spi_pkg::XferIdle) | (state == spi_pkg::XferGap);
    assign xferBusy = (state == spi_pkg::XferLead) | (state == spi_pkg::XferTrail);

    always_comb begin
        nextState = state;
        if (sclkTick) begin
            case (state)
                spi_pkg::XferIdle:
                    nextState = txEmpty ? spi_pkg::XferIdle : spi_pkg::XferLead;
                spi_pkg::XferLead:
                    nextState = spi_pkg::XferTrail;
                spi_pkg::XferTrail:
                    nextState = lastBit ? spi_pkg::XferGap : spi_pkg::XferLead;
                spi_pkg::XferGap:   // Back to back frames skip idle
                    nextState = txEmpty ? spi_pkg::XferIdle : spi_pkg::XferLead;
                default:
                    nextState = spi_pkg::XferIdle;
            endcase
        end
    end

    // Phase 1 drives SCLK active in lead, phase 0 in trail so data leads the edge
    assign clkActive = sckMode[0] ? (nextState == spi_pkg::XferLead) :
                                    (nextState == spi_pkg::XferTrail);

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state   <= spi_pkg::XferIdle;
            bitCnt  <= '0;
            txShift <= '0;
            SPICLK  <= sckMode[1];
        end else begin
            state  <= nextState;
            SPICLK <= sckMode[1] ^ clkActive;
            if (loadFrame) begin
                bitCnt  <= '0;
                txShift <= txHead;
            end else if (shiftBit) begin
                bitCnt  <= bitCnt + 3'd1;
                txShift <= {txShift[`SPI_DATA_W-2:0], 1'b0};   // MSB first
            end
        end
    end

    //////////////////////////////
    // Receive, bits fill from the top so short frames leave low bits zero
    always_ff @(posedge PCLK) begin
        if (loadFrame)
            rxShift <= '0;
        else if (sampleBit)
            rxShift[3'(`SPI_DATA_W-1) - bitCnt] <= SPIIn;
    end

    assign rxByte = rxShift;
    assign SPIOut = txShift[`SPI_DATA_W-1];

    // Chip select, selected line inverted from its default while a frame runs
    assign csSel = `SPI_CS_W'(1) << csId;
    assign SPICS = (csMode == spi_pkg::CsOff || !xferBusy) ? csDef : (csDef ^ csSel);

endmodule

`default_nettype wire

// ==== hw/spiTop.sv ====
// SPI controller top: register file, transmit and receive FIFOs, clock enable, transfer engine
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiTop (
    input  logic                  PCLK,
    input  logic                  PRESETn,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    input  logic                  PWRITE,
    input  logic [7:0]            PADDR,
    input  logic [`SPI_BUS_W-1:0] PWDATA,
    output logic                  PREADY,
    output logic [`SPI_BUS_W-1:0] PRDATA,
    output logic                  SPIOut,
    input  logic                  SPIIn,
    output logic [`SPI_CS_W-1:0]  SPICS,
    output logic                  SPICLK,
    output logic                  SPIIntr
);

    // Configuration
    logic [`SPI_DIV_W-1:0]  sckDiv;
    logic [1:0]             sckMode;
    logic [1:0]             csId;
    logic [`SPI_CS_W-1:0]   csDef;
    spi_pkg::csModeT        csMode;
    logic [3:0]             frameLen;
    // Transmit FIFO
    logic                   txPush;
    logic                   txPop;
    logic [`SPI_DATA_W-1:0] txData;
    logic [`SPI_DATA_W-1:0] txHead;
    logic                   txFull;
    logic                   txEmpty;
    logic [`SPI_FIFO_AW:0]  txCount;
    // Receive FIFO
    logic                   rxPush;
    logic                   rxPop;
    logic [`SPI_DATA_W-1:0] rxByte;
    logic [`SPI_DATA_W-1:0] rxHead;
    logic                   rxEmpty;
    logic [`SPI_FIFO_AW:0]  rxCount;
    // Engine
    logic                   sclkTick;
    logic                   xferIdle;
    logic                   xferBusy;

    spiRegs regs (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
        .txFull, .txEmpty, .txCount, .rxEmpty, .rxCount, .rxHead, .xferIdle, .xferBusy,
        .PREADY, .PRDATA, .SPIIntr, .sckDiv, .sckMode, .csId, .csDef, .csMode, .frameLen,
        .txPush, .txData, .rxPop
    );

    spiFifo #(.Depth(`SPI_FIFO_DEPTH), .Width(`SPI_DATA_W)) txFifo (
        .PCLK, .PRESETn,
        .push(txPush), .pushData(txData), .pop(txPop),
        .popData(txHead), .full(txFull), .empty(txEmpty), .count(txCount)
    );

    spiFifo #(.Depth(`SPI_FIFO_DEPTH), .Width(`SPI_DATA_W)) rxFifo (
        .PCLK, .PRESETn,
        .push(rxPush), .pushData(rxByte), .pop(rxPop),
        .popData(rxHead), .full(), .empty(rxEmpty), .count(rxCount)   // Full FIFO drops frames
    );

    spiClockGen clockGen (.PCLK, .PRESETn, .sckDiv, .sclkTick);

    spiXfer xfer (
        .PCLK, .PRESETn, .sclkTick, .sckMode, .csId, .csDef, .csMode, .frameLen,
        .txEmpty, .txHead, .SPIIn,
        .txPop, .rxPush, .rxByte, .xferIdle, .xferBusy, .SPIOut, .SPICLK, .SPICS
    );

endmodule

`default_nettype wire

// ==== sim/spiMonitor.sv ====
// Monitor comparing read data, interrupt and chip selects, with error counters
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiMonitor (
    input  logic                  PCLK,
    input  logic                  PRESETn,
    input  logic                  PSEL,
    input  logic                  PENABLE,
    input  logic                  PWRITE,
    input  logic [7:0]            PADDR,
    input  logic                  PREADY,
    input  logic [`SPI_BUS_W-1:0] PRDATA,
    input  logic                  SPICLK,
    input  logic [`SPI_CS_W-1:0]  SPICS,
    input  logic                  SPIIntr,
    input  logic                  checkRead,   // Compare this read
    input  logic                  checkIntr,   // Compare SPIIntr with expData[0]
    input  logic [`SPI_BUS_W-1:0] expData,
    input  logic [`SPI_BUS_W-1:0] expMask,
    input  logic                  expPol,      // SCLK idle level
    input  logic [`SPI_CS_W-1:0]  expCs,       // SPICS while SCLK is active
    output int                    valueErrs,
    output int                    csErrs,
    output int                    busErrs
);

    localparam int StallLimit = 5000;   // Longer than one frame at the slowest divider

    logic lastPol;
    int   stall;

    initial begin
        valueErrs = 0;
        csErrs    = 0;
        busErrs   = 0;
        stall     = 0;
        lastPol   = 1'b0;
    end

    always @(posedge PCLK) begin
        if (PSEL && PENABLE && !PWRITE && PREADY && checkRead &&
            ((PRDATA ^ expData) & expMask) !== '0) begin
            $display("FAIL PRDATA at 0x%02h: got 0x%08h expected 0x%08h mask 0x%08h",
                     PADDR, PRDATA, expData, expMask);
            valueErrs++;
        end
        if (checkIntr && SPIIntr !== expData[0]) begin
            $display("FAIL SPIIntr: got 0x%0h expected 0x%0h", SPIIntr, expData[0]);
            valueErrs++;
        end
        // SCLK away from idle means a frame runs, skip the cycle after a polarity change
        if (PRESETn && SPICLK !== expPol && lastPol === expPol && SPICS !== expCs) begin
            $display("FAIL SPICS: got 0x%01h expected 0x%01h", SPICS, expCs);
            csErrs++;
        end
        lastPol <= expPol;
        stall   <= (PSEL && PENABLE && !PREADY) ? stall + 1 : 0;
        if (stall == StallLimit) begin
            $display("PREADY never returned high at address 0x%02h", PADDR);
            busErrs++;
        end
    end

endmodule

`default_nettype wire

// ==== sim/spiChecker.sv ====
// Concurrent protocol assertions on the SPI top level, attached with bind
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiChecker (
    input logic                  PCLK,
    input logic                  PRESETn,
    input logic                  PSEL,
    input logic                  PENABLE,
    input logic                  PWRITE,
    input logic                  PREADY,
    input logic [7:0]            PADDR,
    input logic                  SPICLK,
    input logic [`SPI_CS_W-1:0]  SPICS,
    input logic                  SPIIntr,
    input logic [1:0]            sckMode,
    input logic [`SPI_CS_W-1:0]  csDef,
    input spi_pkg::csModeT       csMode,
    input logic [`SPI_FIFO_AW:0] txCount,
    input logic                  txFull,
    input logic                  txPop,
    input logic [`SPI_FIFO_AW:0] rxCount,
    input logic                  rxEmpty,
    input logic                  rxPush
);

    int   assertErrs;   // Failed assertions so far
    logic txWrite;      // Accepted TXDATA write
    logic rxRead;       // Accepted RXDATA read

    initial assertErrs = 0;

    assign txWrite = PSEL & PENABLE & PWRITE & PREADY &
                     ({PADDR[7:2], 2'b00} == `SPI_REG_TXDATA);
    assign rxRead  = PSEL & PENABLE & ~PWRITE & PREADY &
                     ({PADDR[7:2], 2'b00} == `SPI_REG_RXDATA);

    // Interrupt quiet as reset releases
    assert property (@(posedge PCLK) $rose(PRESETn) |-> !SPIIntr)
        else begin
            $error("SPIIntr high in the first cycle after reset");
            assertErrs++;
        end

    // No clock edges while no chip select is driven, mode 3 leaves SPICS at default
    assert property (@(posedge PCLK) disable iff (!PRESETn)
        (csMode != spi_pkg::CsOff && SPICS == csDef && $stable(sckMode)) |->
        SPICLK == sckMode[1])
        else begin
            $error("SPICLK left its idle level with no chip select active");
            assertErrs++;
        end

    // Write into a full transmit FIFO is lost, only a pop moves the count
    assert property (@(posedge PCLK) disable iff (!PRESETn)
        (txWrite && txFull) |=> txCount == $past(txCount) - $past(txPop))
        else begin
            $error("Transmit write into a full FIFO was not dropped");
            assertErrs++;
        end

    // Read of an empty receive FIFO pops nothing
    assert property (@(posedge PCLK) disable iff (!PRESETn)
        (rxRead && rxEmpty) |=> rxCount == $past(rxCount) + $past(rxPush))
        else begin
            $error("Receive read from an empty FIFO changed its count");
            assertErrs++;
        end

endmodule

bind spiTop spiChecker chk (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PREADY, .PADDR, .SPICLK, .SPICS, .SPIIntr,
    .sckMode, .csDef, .csMode, .txCount, .txFull, .txPop, .rxCount, .rxEmpty, .rxPush
);

`default_nettype wire

// ==== sim/spiTb.sv ====
// Testbench: clock, reset, APB stimulus table run in a loop, watchdog and closing report
`timescale 1ns/1ns
`default_nettype none
`include "spi_params.svh"

module spiTb;

    localparam int OpWrite = 0;
    localparam int OpRead  = 1;     // Read, compare under mask
    localparam int OpPoll  = 2;     // Read until the masked value matches
    localparam int OpIntr  = 3;     // Compare SPIIntr with data bit 0
    localparam int TabMax  = 256;
    localparam int PollMax = 4000;  // Covers one frame at SCKDIV 255

    logic                  PCLK;
    logic                  PRESETn;
    logic                  PSEL;
    logic                  PENABLE;
    logic                  PWRITE;
    logic [7:0]            PADDR;
    logic [`SPI_BUS_W-1:0] PWDATA;
    logic                  PREADY;
    logic [`SPI_BUS_W-1:0] PRDATA;
    logic                  SPIOut;
    logic [`SPI_CS_W-1:0]  SPICS;
    logic                  SPICLK;
    logic                  SPIIntr;
    logic                  checkRead;
    logic                  checkIntr;
    logic [`SPI_BUS_W-1:0] expData;
    logic [`SPI_BUS_W-1:0] expMask;
    logic                  expPol;
    logic [`SPI_CS_W-1:0]  expCs;
    logic [1:0]            csIdM;     // Chip select model, follows register writes
    logic [`SPI_CS_W-1:0]  csDefM;
    logic                  csOffM;
    int                    valueErrs;
    int                    csErrs;
    int                    busErrs;
    int                    pollErrs;
    int                    opTab [TabMax];
    logic [7:0]            addrTab [TabMax];
    logic [`SPI_BUS_W-1:0] dataTab [TabMax];
    logic [`SPI_BUS_W-1:0] maskTab [TabMax];
    int                    tabLen;
    int                    seed;
    logic [7:0]            b;
    logic [7:0]            burst [10];
    longint                limit;

    spiTop DUT (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA, .PREADY, .PRDATA,
        .SPIOut, .SPIIn(SPIOut), .SPICS, .SPICLK, .SPIIntr   // Loopback
    );

    spiMonitor mon (
        .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PREADY, .PRDATA, .SPICLK,
        .SPICS, .SPIIntr, .checkRead, .checkIntr, .expData, .expMask, .expPol, .expCs,
        .valueErrs, .csErrs, .busErrs
    );

    assign expCs = csOffM ? csDefM : (csDefM ^ (`SPI_CS_W'(1) << csIdM));

    initial begin
        PCLK = 1'b0;
        forever #4 PCLK = ~PCLK;
    end

    task automatic add(input int op, input logic [7:0] addr, input logic [31:0] data,
                       input logic [31:0] mask);
        opTab[tabLen]   = op;
        addrTab[tabLen] = addr;
        dataTab[tabLen] = data;
        maskTab[tabLen] = mask;
        tabLen++;
    endtask

    // One byte out and back: send, wait for pending bit 1, compare
    task automatic addLoop(input logic [7:0] sent, input logic [7:0] got);
        add(OpWrite, `SPI_REG_TXDATA, {24'h0, sent}, '0);
        add(OpPoll, `SPI_REG_IP, 32'h2, 32'h2);
        add(OpRead, `SPI_REG_RXDATA, {24'h0, got}, 32'h8000_00FF);
    endtask

    // APB transfer from a falling edge, one idle cycle after it
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = wr;
        PADDR   = addr;
        PWDATA  = wdata;
        @(negedge PCLK);
        PENABLE = 1'b1;
        #1;
        while (!PREADY) begin   // Interlock stall
            @(negedge PCLK);
            #1;
        end
        rdata = PRDATA;
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        @(negedge PCLK);
    endtask

    task automatic runEntry(input int i);
        logic [31:0] rd;
        int          n;
        case (opTab[i])
            OpWrite: begin
                apbXfer(1'b1, addrTab[i], dataTab[i], rd);
                case (addrTab[i])
                    `SPI_REG_SCKMODE: expPol = dataTab[i][1];
                    `SPI_REG_CSID:    csIdM  = dataTab[i][1:0];
                    `SPI_REG_CSDEF:   csDefM = dataTab[i][`SPI_CS_W-1:0];
                    `SPI_REG_CSMODE:  csOffM = (dataTab[i][1:0] == 2'd3);
                    default: ;
                endcase
            end
            OpRead: begin
                expData   = dataTab[i];
                expMask   = maskTab[i];
                checkRead = 1'b1;
                apbXfer(1'b0, addrTab[i], '0, rd);
                checkRead = 1'b0;
            end
            OpPoll: begin
                n = 0;
                apbXfer(1'b0, addrTab[i], '0, rd);
                while (((rd ^ dataTab[i]) & maskTab[i]) != '0 && n < PollMax) begin
                    apbXfer(1'b0, addrTab[i], '0, rd);
                    n++;
                end
                if (n == PollMax) begin
                    $display("Register 0x%02h never reached the awaited value", addrTab[i]);
                    pollErrs++;
                end
            end
            default: begin
                expData   = dataTab[i];
                checkIntr = 1'b1;
                @(negedge PCLK);
                checkIntr = 1'b0;
            end
        endcase
    endtask

    initial begin
        PRESETn   = 1'b0;
        PSEL      = 1'b0;
        PENABLE   = 1'b0;
        PWRITE    = 1'b0;
        PADDR     = '0;
        PWDATA    = '0;
        checkRead = 1'b0;
        checkIntr = 1'b0;
        expData   = '0;
        expMask   = '0;
        expPol    = 1'b0;
        csIdM     = '0;
        csDefM    = `SPI_RST_CSDEF;
        csOffM    = 1'b0;
        pollErrs  = 0;
        tabLen    = 0;
        seed      = 49;

        //////////////////////////////
        // Reset values
        add(OpRead, `SPI_REG_SCKDIV, `SPI_RST_SCKDIV, 32'hFFF);
        add(OpRead, `SPI_REG_CSDEF, 32'hF, 32'hF);
        add(OpRead, `SPI_REG_FMT, 32'h8_0000, 32'hF_0000);
        add(OpRead, `SPI_REG_CSMODE, 0, 32'h3);
        add(OpRead, `SPI_REG_IE, 0, 32'h3);
        add(OpRead, `SPI_REG_IP, 0, 32'h3);
        add(OpIntr, 8'h00, 0, 0);
        // Full frames in all four clock modes
        add(OpWrite, `SPI_REG_SCKDIV, 1, 0);
        for (int m = 0; m < 4; m++) begin
            add(OpWrite, `SPI_REG_SCKMODE, m, 0);
            repeat (2) begin
                b = 8'($random(seed));
                addLoop(b, b);
            end
        end
        // Short frames keep the top L bits
        for (int len = 5; len > 1; len -= 2) begin
            add(OpWrite, `SPI_REG_FMT, len << 16, 0);
            b = 8'($random(seed));
            addLoop(b, b & (8'hFF << (8 - len)));
        end
        add(OpWrite, `SPI_REG_FMT, 32'h8_0000, 0);
        // Chip select in auto and off modes, watched by the monitor
        add(OpWrite, `SPI_REG_CSID, 2, 0);
        add(OpWrite, `SPI_REG_CSDEF, 32'h5, 0);
        b = 8'($random(seed));
        addLoop(b, b);
        add(OpWrite, `SPI_REG_CSMODE, 3, 0);
        b = 8'($random(seed));
        addLoop(b, b);
        add(OpWrite, `SPI_REG_CSMODE, 0, 0);
        add(OpWrite, `SPI_REG_CSDEF, 32'hF, 0);

        //////////////////////////////
        // Full FIFO, tenth write dropped
        for (int k = 0; k < 10; k++)
            burst[k] = 8'($random(seed));
        add(OpWrite, `SPI_REG_SCKDIV, 255, 0);
        add(OpWrite, `SPI_REG_TXDATA, burst[0], 0);
        add(OpPoll, `SPI_REG_RXDATA, 0, 32'h4000_0000);   // First frame in the shifter
        for (int k = 1; k < 9; k++)
            add(OpWrite, `SPI_REG_TXDATA, burst[k], 0);
        add(OpRead, `SPI_REG_TXDATA, 32'h8000_0000, 32'h8000_0000);
        add(OpWrite, `SPI_REG_TXDATA, burst[9], 0);
        for (int k = 0; k < 9; k++) begin
            add(OpPoll, `SPI_REG_IP, 32'h2, 32'h2);
            add(OpRead, `SPI_REG_RXDATA, burst[k], 32'h8000_00FF);
        end
        // Watermark interrupt, then a stalled SCKDIV write
        add(OpWrite, `SPI_REG_SCKDIV, 15, 0);
        add(OpWrite, `SPI_REG_IE, 3, 0);
        add(OpWrite, `SPI_REG_RXMARK, 0, 0);
        b = 8'($random(seed));
        add(OpWrite, `SPI_REG_TXDATA, b, 0);
        add(OpPoll, `SPI_REG_IP, 32'h2, 32'h2);
        add(OpRead, `SPI_REG_IP, 32'h2, 32'h2);
        add(OpIntr, 8'h00, 1, 0);
        add(OpRead, `SPI_REG_RXDATA, b, 32'h8000_00FF);
        add(OpPoll, `SPI_REG_IP, 0, 32'h2);
        add(OpIntr, 8'h00, 0, 0);
        b = 8'($random(seed));
        add(OpWrite, `SPI_REG_TXDATA, b, 0);
        add(OpPoll, `SPI_REG_RXDATA, 0, 32'h4000_0000);
        add(OpWrite, `SPI_REG_SCKDIV, 2, 0);               // Held until the frame ends
        add(OpRead, `SPI_REG_IP, 32'h2, 32'h2);            // So the byte is already in
        add(OpRead, `SPI_REG_SCKDIV, 2, 32'hFFF);
        add(OpRead, `SPI_REG_RXDATA, b, 32'h8000_00FF);

        repeat (3) @(negedge PCLK);
        PRESETn = 1'b1;
        @(negedge PCLK);
        for (int i = 0; i < tabLen; i++)
            runEntry(i);
        repeat (4) @(negedge PCLK);
        $display("Errors: value %0d, chip select %0d, bus %0d, poll %0d, assertion %0d",
                 valueErrs, csErrs, busErrs, pollErrs, DUT.chk.assertErrs);
        if (valueErrs + csErrs + busErrs + pollErrs + DUT.chk.assertErrs == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog, worst case of one slow frame per table entry
    initial begin
        #1;
        limit = longint'(tabLen) * 2 * 9 * 256 * 8 + 20000;
        #(limit);
        $display("Run did not finish within %0d ns", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/spi_pkg.sv
hw/spiRegs.sv
hw/spiFifo.sv
hw/spiClockGen.sv
hw/spiXfer.sv
hw/spiTop.sv
sim/spiMonitor.sv
sim/spiChecker.sv
sim/spiTb.sv
